// File: logic/fetch_pkg.sv
package fetch_pkg;

  // word, address and instruction width
  localparam int xlen = 32;

  // cache line geometry
  localparam int line_words = 2;
  localparam int word_off_w = $clog2(line_words);
  localparam int byte_off_w = 2;

  // opcodes that end straight-line fetch
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_system = 7'b1110011;

  // fence.i, misc-mem opcode with funct3 001
  localparam logic [xlen-1:0] inst_fence_i = 32'h0000_100f;

  // arbiter master indices
  localparam logic master_ifu = 1'b0;
  localparam logic master_lsu = 1'b1;

endpackage

// File: logic/sram_mem.sv
module sram_mem
  import fetch_pkg::*;
#(
  parameter int MEM_WORDS = 1024
) (
  input  logic            clk,
  input  logic            mem_en_i,
  input  logic            mem_we_i,
  input  logic [xlen-1:0] mem_addr_i,
  input  logic [xlen-1:0] mem_wdata_i,
  output logic [xlen-1:0] mem_rdata_o
);

  localparam int aw = $clog2(MEM_WORDS);

  logic [xlen-1:0] mem_q [MEM_WORDS];
  logic [xlen-1:0] rdata_q;
  logic [xlen-1:0] word_num;
  logic [aw-1:0]   word_addr;

  // byte address to word index, wrapped to the array size
  assign word_num  = {2'b00, mem_addr_i[xlen-1:2]};
  assign word_addr = aw'(word_num % xlen'(MEM_WORDS));

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_en_i) begin
      if (mem_we_i) begin
        mem_q[word_addr] <= mem_wdata_i;
      end else begin
        rdata_q <= mem_q[word_addr];
      end
    end
  end

  // read data valid one cycle after the request
  assign mem_rdata_o = rdata_q;

endmodule

// File: logic/mem_arbiter.sv
module mem_arbiter
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            ifu_req_i,
  input  logic            ifu_we_i,
  input  logic [xlen-1:0] ifu_addr_i,
  input  logic [xlen-1:0] ifu_wdata_i,
  input  logic            lsu_req_i,
  input  logic            lsu_we_i,
  input  logic [xlen-1:0] lsu_addr_i,
  input  logic [xlen-1:0] lsu_wdata_i,
  input  logic [xlen-1:0] mem_rdata_i,
  output logic            ifu_gnt_o,
  output logic            lsu_gnt_o,
  output logic            ifu_rvalid_o,
  output logic [xlen-1:0] ifu_rdata_o,
  output logic            lsu_rvalid_o,
  output logic [xlen-1:0] lsu_rdata_o,
  output logic            mem_en_o,
  output logic            mem_we_o,
  output logic [xlen-1:0] mem_addr_o,
  output logic [xlen-1:0] mem_wdata_o
);

  logic prio_q;
  logic rd_pend_q;
  logic rd_owner_q;
  logic sel;

  // priority only matters when both ask
  assign ifu_gnt_o = ifu_req_i && (!lsu_req_i || prio_q == master_ifu);
  assign lsu_gnt_o = lsu_req_i && (!ifu_req_i || prio_q == master_lsu);
  assign sel       = lsu_gnt_o ? master_lsu : master_ifu;

  assign mem_en_o    = ifu_gnt_o || lsu_gnt_o;
  assign mem_we_o    = (sel == master_lsu) ? lsu_we_i : ifu_we_i;
  assign mem_addr_o  = (sel == master_lsu) ? lsu_addr_i : ifu_addr_i;
  assign mem_wdata_o = (sel == master_lsu) ? lsu_wdata_i : ifu_wdata_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      prio_q     <= master_ifu;
      rd_pend_q  <= 1'b0;
      rd_owner_q <= master_ifu;
    end else begin
      if (mem_en_o) begin
        prio_q <= ~sel;
      end
      rd_pend_q  <= mem_en_o && !mem_we_o;
      rd_owner_q <= sel;
    end
  end

  // return data goes to whoever owned last cycle's read
  assign ifu_rvalid_o = rd_pend_q && rd_owner_q == master_ifu;
  assign lsu_rvalid_o = rd_pend_q && rd_owner_q == master_lsu;
  assign ifu_rdata_o  = mem_rdata_i;
  assign lsu_rdata_o  = mem_rdata_i;

  // after a grant the other master goes first when both ask
  a_round_robin: assert property (@(posedge clk) disable iff (rst)
    ifu_req_i && lsu_req_i && $past(mem_en_o) |-> lsu_gnt_o == $past(ifu_gnt_o));

endmodule

// File: logic/data_port.sv
module data_port
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            dreq_valid_i,
  input  logic            dreq_write_i,
  input  logic [xlen-1:0] dreq_addr_i,
  input  logic [xlen-1:0] dreq_wdata_i,
  input  logic            bus_gnt_i,
  input  logic            bus_rvalid_i,
  input  logic [xlen-1:0] bus_rdata_i,
  output logic            dreq_ready_o,
  output logic            drsp_valid_o,
  output logic [xlen-1:0] drsp_rdata_o,
  output logic            bus_req_o,
  output logic            bus_we_o,
  output logic [xlen-1:0] bus_addr_o,
  output logic [xlen-1:0] bus_wdata_o
);

  typedef enum logic [1:0] {st_idle, st_req, st_read} state_t;

  state_t          state_q;
  logic            we_q;
  logic [xlen-1:0] addr_q;
  logic [xlen-1:0] wdata_q;

  assign dreq_ready_o = (state_q == st_idle);
  assign bus_req_o    = (state_q == st_req);
  assign bus_we_o     = we_q;
  assign bus_addr_o   = addr_q;
  assign bus_wdata_o  = wdata_q;

  // writes answer at the grant, reads when the data comes back
  assign drsp_valid_o = (bus_req_o && bus_gnt_i && we_q) ||
                        (state_q == st_read && bus_rvalid_i);
  assign drsp_rdata_o = bus_rdata_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: if (dreq_valid_i) state_q <= st_req;
        st_req:  if (bus_gnt_i) state_q <= we_q ? st_idle : st_read;
        st_read: if (bus_rvalid_i) state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (dreq_ready_o && dreq_valid_i) begin
      we_q    <= dreq_write_i;
      addr_q  <= dreq_addr_i;
      wdata_q <= dreq_wdata_i;
    end
  end

  // arbiter must hand the read data back on the very next cycle
  a_read_return: assert property (@(posedge clk) disable iff (rst)
    bus_req_o && bus_gnt_i && !we_q |=> bus_rvalid_i);

endmodule

// File: logic/icache.sv
module icache
  import fetch_pkg::*;
#(
  parameter int ICACHE_SETS = 8
) (
  input  logic            clk,
  input  logic            rst,
  input  logic [xlen-1:0] fetch_addr_i,
  input  logic            flush_i,
  input  logic            bus_gnt_i,
  input  logic            bus_rvalid_i,
  input  logic [xlen-1:0] bus_rdata_i,
  output logic            hit_o,
  output logic [xlen-1:0] hit_inst_o,
  output logic            bus_req_o,
  output logic [xlen-1:0] bus_addr_o
);

  localparam int idx_w = $clog2(ICACHE_SETS);
  localparam int tag_w = xlen - idx_w - word_off_w - byte_off_w;

  typedef enum logic [1:0] {st_idle, st_even, st_odd} state_t;

  state_t                 state_q;
  logic                   awaiting_q;
  logic                   flushed_q;
  logic [tag_w-1:0]       refill_tag_q;
  logic [idx_w-1:0]       refill_idx_q;
  logic [ICACHE_SETS-1:0] valid_q;
  logic [tag_w-1:0]       tag_q [ICACHE_SETS];
  logic [xlen-1:0]        data_q [ICACHE_SETS][line_words];

  logic [tag_w-1:0]      addr_tag;
  logic [idx_w-1:0]      addr_idx;
  logic [word_off_w-1:0] addr_off;
  logic [word_off_w-1:0] beat_off;
  logic                  refill_start;
  logic                  beat_done;

  assign addr_tag = fetch_addr_i[xlen-1 -: tag_w];
  assign addr_idx = fetch_addr_i[byte_off_w + word_off_w +: idx_w];
  assign addr_off = fetch_addr_i[byte_off_w +: word_off_w];

  // combinational lookup
  assign hit_o      = valid_q[addr_idx] && (tag_q[addr_idx] == addr_tag);
  assign hit_inst_o = data_q[addr_idx][addr_off];

  assign refill_start = (state_q == st_idle) && !hit_o;
  assign beat_done    = awaiting_q && bus_rvalid_i;

  assign beat_off   = (state_q == st_odd) ? word_off_w'(1) : '0;
  assign bus_req_o  = (state_q != st_idle) && !awaiting_q;
  assign bus_addr_o = {refill_tag_q, refill_idx_q, beat_off, {byte_off_w{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= st_idle;
      awaiting_q <= 1'b0;
      flushed_q  <= 1'b0;
      valid_q    <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (refill_start) begin
            state_q           <= st_even;
            flushed_q         <= 1'b0;
            // line is overwritten word by word
            valid_q[addr_idx] <= 1'b0;
          end
        end
        st_even: begin
          if (bus_req_o && bus_gnt_i) begin
            awaiting_q <= 1'b1;
          end else if (beat_done) begin
            awaiting_q <= 1'b0;
            state_q    <= st_odd;
          end
        end
        st_odd: begin
          if (bus_req_o && bus_gnt_i) begin
            awaiting_q <= 1'b1;
          end else if (beat_done) begin
            awaiting_q <= 1'b0;
            state_q    <= st_idle;
            if (!flushed_q) begin
              valid_q[refill_idx_q] <= 1'b1;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
      // flash invalidate wins over a refill finishing this cycle
      if (flush_i) begin
        valid_q <= '0;
        if (state_q != st_idle) begin
          flushed_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (refill_start) begin
      refill_tag_q <= addr_tag;
      refill_idx_q <= addr_idx;
    end
    if (beat_done) begin
      data_q[refill_idx_q][beat_off] <= bus_rdata_i;
      if (state_q == st_odd) begin
        tag_q[refill_idx_q] <= refill_tag_q;
      end
    end
  end

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    bus_req_o && !bus_gnt_i |=> bus_req_o && $stable(bus_addr_o));

endmodule

// File: logic/fetch_unit.sv
module fetch_unit
  import fetch_pkg::*;
#(
  parameter logic [xlen-1:0] RESET_PC      = '0,
  parameter int              FETCH_CREDITS = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            credit_return_i,
  input  logic            redirect_valid_i,
  input  logic            redirect_taken_i,
  input  logic [xlen-1:0] redirect_pc_i,
  input  logic            hit_i,
  input  logic [xlen-1:0] hit_inst_i,
  output logic [xlen-1:0] fetch_addr_o,
  output logic            inst_valid_o,
  output logic [xlen-1:0] inst_o,
  output logic [xlen-1:0] pc_o,
  output logic            flush_o
);

  localparam int cred_w = $clog2(FETCH_CREDITS + 1);

  logic [xlen-1:0]   pc_q;
  logic [cred_w-1:0] credits_q;
  logic              stall_q;
  logic [6:0]        opcode;
  logic              is_ctrl;
  logic              emit;

  assign opcode  = hit_inst_i[6:0];
  assign is_ctrl = (opcode == op_jal) || (opcode == op_jalr) ||
                   (opcode == op_branch) || (opcode == op_system);

  assign emit = hit_i && (credits_q != '0) && !stall_q;

  assign fetch_addr_o = pc_q;
  assign pc_o         = pc_q;
  assign inst_o       = hit_inst_i;
  assign inst_valid_o = emit;
  assign flush_o      = emit && (hit_inst_i == inst_fence_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q      <= RESET_PC;
      credits_q <= cred_w'(FETCH_CREDITS);
      stall_q   <= 1'b0;
    end else begin
      // spend and return together leave the count alone
      case ({emit, credit_return_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase

      if (emit) begin
        if (is_ctrl) begin
          stall_q <= 1'b1;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end else if (stall_q && redirect_valid_i) begin
        stall_q <= 1'b0;
        pc_q    <= redirect_taken_i ? redirect_pc_i : pc_q + 32'd4;
      end
    end
  end

  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits_q <= cred_w'(FETCH_CREDITS));

  // nothing in the cycle after a control transfer
  a_ctrl_stall: assert property (@(posedge clk) disable iff (rst)
    inst_valid_o && is_ctrl |=> !inst_valid_o);

endmodule

// File: logic/fetch_subsystem_top.sv
module fetch_subsystem_top
  import fetch_pkg::*;
#(
  parameter int              ICACHE_SETS   = 8,
  parameter int              MEM_WORDS     = 1024,
  parameter logic [xlen-1:0] RESET_PC      = '0,
  parameter int              FETCH_CREDITS = 4
) (
  input  logic            clk,
  input  logic            rst,
  output logic            inst_valid_o,
  output logic [xlen-1:0] inst_o,
  output logic [xlen-1:0] pc_o,
  input  logic            credit_return_i,
  input  logic            redirect_valid_i,
  input  logic            redirect_taken_i,
  input  logic [xlen-1:0] redirect_pc_i,
  input  logic            dreq_valid_i,
  input  logic            dreq_write_i,
  input  logic [xlen-1:0] dreq_addr_i,
  input  logic [xlen-1:0] dreq_wdata_i,
  output logic            dreq_ready_o,
  output logic            drsp_valid_o,
  output logic [xlen-1:0] drsp_rdata_o
);

  logic [xlen-1:0] fetch_addr;
  logic            hit;
  logic [xlen-1:0] hit_inst;
  logic            flush;

  // cache refill master
  logic            ic_req;
  logic [xlen-1:0] ic_addr;
  logic            ic_gnt;
  logic            ic_rvalid;
  logic [xlen-1:0] ic_rdata;

  // data port master
  logic            dp_req;
  logic            dp_we;
  logic [xlen-1:0] dp_addr;
  logic [xlen-1:0] dp_wdata;
  logic            dp_gnt;
  logic            dp_rvalid;
  logic [xlen-1:0] dp_rdata;

  logic            mem_en;
  logic            mem_we;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] mem_wdata;
  logic [xlen-1:0] mem_rdata;

  fetch_unit #(
    .RESET_PC      (RESET_PC),
    .FETCH_CREDITS (FETCH_CREDITS)
  ) u_fetch (
    .clk              (clk),
    .rst              (rst),
    .credit_return_i  (credit_return_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_taken_i (redirect_taken_i),
    .redirect_pc_i    (redirect_pc_i),
    .hit_i            (hit),
    .hit_inst_i       (hit_inst),
    .fetch_addr_o     (fetch_addr),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o),
    .pc_o             (pc_o),
    .flush_o          (flush)
  );

  icache #(
    .ICACHE_SETS (ICACHE_SETS)
  ) u_icache (
    .clk          (clk),
    .rst          (rst),
    .fetch_addr_i (fetch_addr),
    .flush_i      (flush),
    .bus_gnt_i    (ic_gnt),
    .bus_rvalid_i (ic_rvalid),
    .bus_rdata_i  (ic_rdata),
    .hit_o        (hit),
    .hit_inst_o   (hit_inst),
    .bus_req_o    (ic_req),
    .bus_addr_o   (ic_addr)
  );

  data_port u_dport (
    .clk          (clk),
    .rst          (rst),
    .dreq_valid_i (dreq_valid_i),
    .dreq_write_i (dreq_write_i),
    .dreq_addr_i  (dreq_addr_i),
    .dreq_wdata_i (dreq_wdata_i),
    .bus_gnt_i    (dp_gnt),
    .bus_rvalid_i (dp_rvalid),
    .bus_rdata_i  (dp_rdata),
    .dreq_ready_o (dreq_ready_o),
    .drsp_valid_o (drsp_valid_o),
    .drsp_rdata_o (drsp_rdata_o),
    .bus_req_o    (dp_req),
    .bus_we_o     (dp_we),
    .bus_addr_o   (dp_addr),
    .bus_wdata_o  (dp_wdata)
  );

  // refill only ever reads
  mem_arbiter u_arb (
    .clk          (clk),
    .rst          (rst),
    .ifu_req_i    (ic_req),
    .ifu_we_i     (1'b0),
    .ifu_addr_i   (ic_addr),
    .ifu_wdata_i  ('0),
    .lsu_req_i    (dp_req),
    .lsu_we_i     (dp_we),
    .lsu_addr_i   (dp_addr),
    .lsu_wdata_i  (dp_wdata),
    .mem_rdata_i  (mem_rdata),
    .ifu_gnt_o    (ic_gnt),
    .lsu_gnt_o    (dp_gnt),
    .ifu_rvalid_o (ic_rvalid),
    .ifu_rdata_o  (ic_rdata),
    .lsu_rvalid_o (dp_rvalid),
    .lsu_rdata_o  (dp_rdata),
    .mem_en_o     (mem_en),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata)
  );

  sram_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk         (clk),
    .mem_en_i    (mem_en),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_rdata_o (mem_rdata)
  );

endmodule

// File: testbench/fetch_model.sv
module fetch_model #(
  parameter int MEM_WORDS = 256
) ();

  // backing memory, and the words that fetch is expected to see
  logic [31:0] mem_m  [MEM_WORDS];
  logic [31:0] view_m [MEM_WORDS];
  int          checks;
  int          errors;

  initial begin
    checks = 0;
    errors = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_m[i]  = 32'h0;
      view_m[i] = 32'h0;
    end
  end

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) % MEM_WORDS);
  endfunction

  // visible is low for a store over code that may sit in the cache
  task automatic store(input logic [31:0] addr, input logic [31:0] data, input bit visible);
    mem_m[word_index(addr)] = data;
    if (visible) begin
      view_m[word_index(addr)] = data;
    end
  endtask

  // fence.i makes every stored word visible to fetch
  task automatic sync_view();
    for (int i = 0; i < MEM_WORDS; i++) begin
      view_m[i] = mem_m[i];
    end
  endtask

  function automatic logic [31:0] load_word(input logic [31:0] addr);
    return mem_m[word_index(addr)];
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    return view_m[word_index(addr)];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

endmodule

// File: testbench/tb_fetch.sv
module tb_fetch
  import fetch_pkg::*;
();

  localparam int          sets      = 8;
  localparam int          mem_words = 256;
  localparam logic [31:0] reset_pc  = 32'h0;
  localparam int          credits   = 3;
  localparam int          n_data    = 170;
  localparam int          n_inst    = 2600;
  // twice the worst case of all tests together
  localparam int          limit     = 2 * (n_data * 10 + n_inst * 30);

  logic        clk;
  logic        rst;
  logic        inst_valid_o;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic        credit_return_i  = 1'b0;
  logic        redirect_valid_i = 1'b0;
  logic        redirect_taken_i = 1'b0;
  logic [31:0] redirect_pc_i    = 32'h0;
  logic        dreq_valid_i;
  logic        dreq_write_i;
  logic [31:0] dreq_addr_i;
  logic [31:0] dreq_wdata_i;
  logic        dreq_ready_o;
  logic        drsp_valid_o;
  logic [31:0] drsp_rdata_o;

  // monitor state
  logic [31:0] model_pc  = reset_pc;
  logic [31:0] exp_inst  = 32'h0;
  bit          pending   = 1'b0;
  bit          redir_req = 1'b0;
  bit          redir_tk  = 1'b0;
  logic [31:0] redir_pc  = 32'h0;
  bit          ret_en    = 1'b0;
  bit          hold_en   = 1'b0;
  int          hold      = 0;
  int          emitted   = 0;
  int          returned  = 0;
  int          cycles    = 0;
  int          ret_q[$];

  fetch_subsystem_top #(
    .ICACHE_SETS   (sets),
    .MEM_WORDS     (mem_words),
    .RESET_PC      (reset_pc),
    .FETCH_CREDITS (credits)
  ) u_dut (
    .clk              (clk),
    .rst              (rst),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o),
    .pc_o             (pc_o),
    .credit_return_i  (credit_return_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_taken_i (redirect_taken_i),
    .redirect_pc_i    (redirect_pc_i),
    .dreq_valid_i     (dreq_valid_i),
    .dreq_write_i     (dreq_write_i),
    .dreq_addr_i      (dreq_addr_i),
    .dreq_wdata_i     (dreq_wdata_i),
    .dreq_ready_o     (dreq_ready_o),
    .drsp_valid_o     (drsp_valid_o),
    .drsp_rdata_o     (drsp_rdata_o)
  );

  fetch_model #(.MEM_WORDS(mem_words)) u_model ();

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic bit is_transfer(input logic [31:0] w);
    return w[6:0] == op_jal || w[6:0] == op_jalr || w[6:0] == op_branch ||
           w[6:0] == op_system;
  endfunction

  function automatic logic [31:0] rand_plain();
    logic [6:0] op;
    case ($urandom_range(0, 4))
      0: op = 7'b0010011;
      1: op = 7'b0110011;
      2: op = 7'b0000011;
      3: op = 7'b0100011;
      default: op = 7'b0110111;
    endcase
    return {25'($urandom), op};
  endfunction

  function automatic logic [31:0] rand_transfer();
    logic [6:0] op;
    case ($urandom_range(0, 3))
      0: op = op_jal;
      1: op = op_jalr;
      2: op = op_branch;
      default: op = op_system;
    endcase
    return {25'($urandom), op};
  endfunction

  // emitted stream, credit returns and redirects
  always @(negedge clk) begin
    credit_return_i  = 1'b0;
    redirect_valid_i = 1'b0;
    if (!rst) begin
      if (inst_valid_o) begin
        exp_inst = u_model.fetch_word(model_pc);
        if (pending) begin
          u_model.errors++;
          $display("instruction emitted while waiting for a redirect");
        end
        u_model.check("pc_o", pc_o, model_pc);
        u_model.check("inst_o", inst_o, exp_inst);
        if (emitted - returned >= credits) begin
          u_model.errors++;
          $display("credit overrun: instruction emitted with %0d unanswered",
                   emitted - returned);
        end
        emitted++;
        if (is_transfer(exp_inst)) begin
          pending = 1'b1;
        end else begin
          model_pc = model_pc + 32'd4;
        end
        if (exp_inst == inst_fence_i) begin
          u_model.sync_view();
        end
      end else if (pending && redir_req) begin
        redirect_valid_i = 1'b1;
        redirect_taken_i = redir_tk;
        redirect_pc_i    = redir_pc;
        model_pc  = redir_tk ? redir_pc : model_pc + 32'd4;
        pending   = 1'b0;
        redir_req = 1'b0;
      end
      for (int i = 0; i < ret_q.size(); i++) begin
        if (ret_q[i] > 0) ret_q[i] = ret_q[i] - 1;
      end
      if (inst_valid_o) begin
        ret_q.push_back(int'($urandom_range(1, 5)));
      end
      if (hold > 0) begin
        hold--;
      end else if (hold_en && $urandom_range(0, 15) == 0) begin
        hold = int'($urandom_range(3, 10));
      end
      if (ret_en && hold == 0 && ret_q.size() > 0 && ret_q[0] == 0) begin
        void'(ret_q.pop_front());
        credit_return_i = 1'b1;
        returned++;
      end
    end
  end

  task automatic data_op(input bit wr, input logic [31:0] addr, input logic [31:0] data,
                         input bit visible);
    @(negedge clk);
    while (!dreq_ready_o) @(negedge clk);
    dreq_valid_i = 1'b1;
    dreq_write_i = wr;
    dreq_addr_i  = addr;
    dreq_wdata_i = data;
    @(negedge clk);
    dreq_valid_i = 1'b0;
    while (!drsp_valid_o) @(negedge clk);
    if (wr) begin
      u_model.store(addr, data, visible);
    end else begin
      u_model.check("drsp_rdata_o", drsp_rdata_o, u_model.load_word(addr));
    end
  endtask

  task automatic wait_stall();
    while (!pending) @(negedge clk);
  endtask

  task automatic redirect(input bit taken, input logic [31:0] target);
    redir_tk  = taken;
    redir_pc  = target;
    redir_req = 1'b1;
    while (redir_req) @(negedge clk);
  endtask

  // bounces around the code block at 0x100
  task automatic run_transfers(input int n);
    bit taken;
    for (int i = 0; i < n; i++) begin
      wait_stall();
      taken = 1'($urandom_range(0, 1));
      if (model_pc < 32'h100 || model_pc > 32'h1f8) taken = 1'b1;
      redirect(taken, 32'h100 + 32'(4 * $urandom_range(0, 63)));
    end
  endtask

  task automatic report(input string name, input int err_before);
    $display("test %s: %s", name, (u_model.errors == err_before) ? "ok" : "failed");
  endtask

  logic [31:0] addrs[$];
  logic [31:0] old_w;
  int          err0;
  int          emit0;

  initial begin
    void'($urandom(32'he558_75a7));
    dreq_valid_i = 1'b0;
    dreq_write_i = 1'b0;
    dreq_addr_i  = 32'h0;
    dreq_wdata_i = 32'h0;
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // credits withheld, fetch stops at 0x0c
    err0 = u_model.errors;
    for (int i = 0; i < 16; i++) begin
      addrs.push_back(32'h200 + 32'(4 * $urandom_range(0, 127)));
      data_op(1'b1, addrs[i], $urandom, 1'b1);
    end
    foreach (addrs[i]) data_op(1'b0, addrs[i], 32'h0, 1'b1);
    report("data port", err0);

    err0 = u_model.errors;
    for (int i = 0; i < 12; i++) data_op(1'b1, 32'h10 + 32'(4 * i), rand_plain(), 1'b1);
    data_op(1'b1, 32'h40, {25'h0, op_jal}, 1'b1);
    ret_en = 1'b1;
    wait_stall();
    report("straight-line fetch", err0);

    err0 = u_model.errors;
    for (int i = 0; i < 15; i++) data_op(1'b1, 32'h80 + 32'(4 * i), rand_plain(), 1'b1);
    data_op(1'b1, 32'hbc, {25'h1, op_jal}, 1'b1);
    hold_en = 1'b1;
    emit0 = emitted;
    redirect(1'b1, 32'h80);
    wait_stall();
    hold_en = 1'b0;
    u_model.check("emitted", 32'(emitted - emit0), 32'd16);
    report("credits", err0);

    err0 = u_model.errors;
    for (int i = 0; i < 64; i++) begin
      if (i == 63) begin
        data_op(1'b1, 32'h1fc, {25'h2, op_jal}, 1'b1);
      end else if ($urandom_range(0, 3) == 0) begin
        data_op(1'b1, 32'h100 + 32'(4 * i), rand_transfer(), 1'b1);
      end else begin
        data_op(1'b1, 32'h100 + 32'(4 * i), rand_plain(), 1'b1);
      end
    end
    redirect(1'b1, 32'h100);
    run_transfers(20);
    report("control transfers", err0);

    // old word stays cached until fence.i
    err0 = u_model.errors;
    wait_stall();
    old_w = rand_plain();
    data_op(1'b1, 32'hc0, old_w, 1'b1);
    data_op(1'b1, 32'hc4, {25'h3, op_jal}, 1'b1);
    redirect(1'b1, 32'hc0);
    wait_stall();
    data_op(1'b1, 32'hc0, ~old_w & 32'hffff_ff80 | 32'h13, 1'b0);
    redirect(1'b1, 32'hc0);
    wait_stall();
    data_op(1'b1, 32'hc8, inst_fence_i, 1'b1);
    data_op(1'b1, 32'hcc, {25'h4, op_jal}, 1'b1);
    redirect(1'b0, 32'h0);
    wait_stall();
    redirect(1'b1, 32'hc0);
    wait_stall();
    report("coherence", err0);

    err0 = u_model.errors;
    fork
      run_transfers(20);
      for (int i = 0; i < 30; i++) begin
        data_op(1'($urandom_range(0, 1)), 32'h200 + 32'(4 * $urandom_range(0, 127)),
                $urandom, 1'b1);
      end
    join
    report("contention", err0);

    $display("checks %0d, errors %0d", u_model.checks, u_model.errors);
    if (u_model.errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: filelist.f
logic/fetch_pkg.sv
logic/sram_mem.sv
logic/mem_arbiter.sv
logic/data_port.sv
logic/icache.sv
logic/fetch_unit.sv
logic/fetch_subsystem_top.sv
testbench/fetch_model.sv
testbench/tb_fetch.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_fetch -o tb_sim
	out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
